// File: hw/stk_pkg.sv
`default_nettype none

package stk_pkg;

  // Push payload width
  localparam int DAT_W = 128;

  // Engine count used when the top level is not overridden
  localparam int ENGS_N_DEFAULT = 4;

  // Entries per command queue
  localparam int QUEUE_DEPTH_DEFAULT = 2;

  // Command opcode width
  localparam int OPCODE_W = 2;

  // Push payload as carried through the pipe
  typedef logic [DAT_W - 1:0] dat_t;

  // Command opcode
  typedef logic [OPCODE_W - 1:0] opcode_t;

  // Supported opcodes
  // Any other encoding on a valid command is never acknowledged
  localparam opcode_t OPCODE_PUSH = opcode_t'(1);
  localparam opcode_t OPCODE_POP = opcode_t'(2);

endpackage : stk_pkg

`default_nettype wire

// File: hw/stk_rr_arb.sv
`timescale 1ns/1ps
`default_nettype none

module stk_rr_arb #(
  parameter int W = 2
) (
  input wire logic [W - 1:0]          i_req
, input wire logic                    i_ack
, output wire logic [W - 1:0]         o_gnt
, input wire logic                    clk
, input wire logic                    i_arst_n
);

  // Pointer needs at least one bit even for a single requester
  localparam int PTR_W = (W > 1) ? $clog2(W) : 1;

  logic [PTR_W - 1:0]                 ptr_r;
  logic [PTR_W - 1:0]                 gnt_idx;
  logic [W - 1:0]                     gnt;

  // Scan from the pointer upwards, wrapping at W
  // First requester found wins
  always_comb begin
    int   idx;
    logic found;
    gnt     = '0;
    gnt_idx = '0;
    found   = 1'b0;
    for (int i = 0; i < W; i++) begin
      idx = int'(ptr_r) + i;
      if (idx >= W) begin
        idx = idx - W;
      end
      if (!found && i_req[idx]) begin
        found        = 1'b1;
        gnt[idx]     = 1'b1;
        gnt_idx      = PTR_W'(idx);
      end
    end
  end

  // Priority moves just past the winner once it is taken
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ptr_r <= '0;
    end else if (i_ack) begin
      ptr_r <= (gnt_idx == PTR_W'(W - 1)) ? '0 : gnt_idx + 1'b1;
    end
  end

  assign o_gnt = gnt;

endmodule : stk_rr_arb

`default_nettype wire

// File: hw/stk_cmd_queue.sv
`timescale 1ns/1ps
`default_nettype none

module stk_cmd_queue #(
  parameter int DEPTH = stk_pkg::QUEUE_DEPTH_DEFAULT
, parameter int W = 8
) (
  input wire logic                    i_push
, input wire logic [W - 1:0]          i_push_dat
, input wire logic                    i_pop
, output wire logic [W - 1:0]         o_pop_dat
, output wire logic                   o_full
, output wire logic                   o_empty
, input wire logic                    clk
, input wire logic                    i_arst_n
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Entry storage
  logic [W - 1:0]                     mem [DEPTH];

  logic [PTR_W - 1:0]                 wr_ptr_r;
  logic [PTR_W - 1:0]                 rd_ptr_r;
  logic [CNT_W - 1:0]                 cnt_r;
  logic [CNT_W - 1:0]                 cnt_w;
  logic                               full_r;
  logic                               empty_r;
  logic                               wr_en;
  logic                               rd_en;

  // Guard against overflow and underflow
  assign wr_en = i_push & ~full_r;
  assign rd_en = i_pop & ~empty_r;

  // Occupancy after this cycle
  assign cnt_w = cnt_r + CNT_W'(wr_en) - CNT_W'(rd_en);

  // Pointers wrap explicitly so DEPTH need not be a power of two
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      cnt_r    <= '0;
      full_r   <= 1'b0;
      empty_r  <= 1'b1;
    end else begin
      if (wr_en) begin
        wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      cnt_r   <= cnt_w;
      // Flags registered from next occupancy
      full_r  <= (cnt_w == CNT_W'(DEPTH));
      empty_r <= (cnt_w == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr_r] <= i_push_dat;
    end
  end

  // Head entry presented combinationally
  assign o_pop_dat = mem[rd_ptr_r];
  assign o_full    = full_r;
  assign o_empty   = empty_r;

endmodule : stk_cmd_queue

`default_nettype wire

// File: hw/stk_cmd_enq.sv
`timescale 1ns/1ps
`default_nettype none

module stk_cmd_enq #(
  parameter int ENGS_N = stk_pkg::ENGS_N_DEFAULT
, localparam int ENGID_W = $clog2(ENGS_N)
) (
  input wire logic [ENGS_N - 1:0]                 i_cmd_vld
, input wire stk_pkg::opcode_t [ENGS_N - 1:0]     i_cmd_opcode
, input wire stk_pkg::dat_t [ENGS_N - 1:0]        i_cmd_dat
, input wire logic                                i_qpush_full
, input wire logic                                i_qpop_full
, output wire logic [ENGS_N - 1:0]                o_cmd_ack
, output wire logic                               o_qpush_push
, output wire logic [ENGID_W + stk_pkg::DAT_W - 1:0]
                                                  o_qpush_dat
, output wire logic                               o_qpop_push
, output wire logic [ENGID_W - 1:0]               o_qpop_dat
, input wire logic                                clk
, input wire logic                                i_arst_n
);

  import stk_pkg::*;

  logic [ENGS_N - 1:0]                cmd_is_push;
  logic [ENGS_N - 1:0]                cmd_is_pop;
  logic [ENGS_N - 1:0]                enq_req;
  logic [ENGS_N - 1:0]                enq_gnt;
  logic                               enq_ack;
  logic [ENGID_W - 1:0]               gnt_engid;
  dat_t                               gnt_dat;

  // Per-engine opcode decode, qualified by valid
  for (genvar e = 0; e < ENGS_N; e++) begin : g_dec
    assign cmd_is_push[e] = i_cmd_vld[e] & (i_cmd_opcode[e] == OPCODE_PUSH);
    assign cmd_is_pop[e]  = i_cmd_vld[e] & (i_cmd_opcode[e] == OPCODE_POP);
  end : g_dec

  // Only commands whose target queue has room may compete
  assign enq_req = (cmd_is_push & {ENGS_N{~i_qpush_full}})
                 | (cmd_is_pop & {ENGS_N{~i_qpop_full}});

  stk_rr_arb #(.W(ENGS_N)) u_enq_arb (
    .i_req                    (enq_req)
  , .i_ack                    (enq_ack)
  , .o_gnt                    (enq_gnt)
  , .clk                      (clk)
  , .i_arst_n                 (i_arst_n)
  );

  // One-hot grant to engine ID and data
  // OR reduction is safe since at most one bit is set
  always_comb begin
    gnt_engid = '0;
    gnt_dat   = '0;
    for (int e = 0; e < ENGS_N; e++) begin
      if (enq_gnt[e]) begin
        gnt_engid = gnt_engid | ENGID_W'(e);
        gnt_dat   = gnt_dat | i_cmd_dat[e];
      end
    end
  end

  // Route the winner to its queue
  assign o_qpush_push = (enq_gnt & cmd_is_push) != '0;
  assign o_qpop_push  = (enq_gnt & cmd_is_pop) != '0;

  // Priority advances whenever something is enqueued
  assign enq_ack = o_qpush_push | o_qpop_push;

  // Push entry is ID on top of payload
  assign o_qpush_dat = {gnt_engid, gnt_dat};
  assign o_qpop_dat  = gnt_engid;

  // Same-cycle acknowledge back to the engine
  assign o_cmd_ack = enq_gnt & {ENGS_N{enq_ack}};

endmodule : stk_cmd_enq

`default_nettype wire

// File: hw/stk_active_set.sv
`timescale 1ns/1ps
`default_nettype none

module stk_active_set #(
  parameter int ENGS_N = stk_pkg::ENGS_N_DEFAULT
, localparam int ENGID_W = $clog2(ENGS_N)
) (
  input wire logic                    i_issue
, input wire logic [ENGID_W - 1:0]    i_issue_engid
, input wire logic                    i_wrbk_vld
, input wire logic [ENGID_W - 1:0]    i_wrbk_engid
, input wire logic [ENGID_W - 1:0]    i_qpush_head_engid
, input wire logic [ENGID_W - 1:0]    i_qpop_head_engid
, output wire logic                   o_qpush_blocked
, output wire logic                   o_qpop_blocked
, input wire logic                    clk
, input wire logic                    i_arst_n
);

  // One bit per engine with a command in flight
  logic [ENGS_N - 1:0]                active_r;
  logic [ENGS_N - 1:0]                active_w;
  logic [ENGS_N - 1:0]                set_d;
  logic [ENGS_N - 1:0]                clr_d;

  // Decode issue and writeback IDs into masks
  for (genvar e = 0; e < ENGS_N; e++) begin : g_mask
    assign set_d[e] = i_issue & (i_issue_engid == ENGID_W'(e));
    assign clr_d[e] = i_wrbk_vld & (i_wrbk_engid == ENGID_W'(e));
  end : g_mask

  // Set then clear, so a same-cycle writeback wins
  assign active_w = (active_r | set_d) & ~clr_d;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      active_r <= '0;
    end else begin
      active_r <= active_w;
    end
  end

  // Heads are blocked by the registered bitmap only
  assign o_qpush_blocked = active_r[i_qpush_head_engid];
  assign o_qpop_blocked  = active_r[i_qpop_head_engid];

endmodule : stk_active_set

`default_nettype wire

// File: hw/stk_issue.sv
`timescale 1ns/1ps
`default_nettype none

module stk_issue #(
  parameter int ENGS_N = stk_pkg::ENGS_N_DEFAULT
, localparam int ENGID_W = $clog2(ENGS_N)
) (
  input wire logic                    i_qpush_empty
, input wire logic [ENGID_W - 1:0]    i_qpush_head_engid
, input wire stk_pkg::dat_t           i_qpush_head_dat
, input wire logic                    i_qpush_blocked
, input wire logic                    i_qpop_empty
, input wire logic [ENGID_W - 1:0]    i_qpop_head_engid
, input wire logic                    i_qpop_blocked
, input wire logic                    i_al_busy_r
, input wire logic                    i_al_full_r
, output wire logic                   o_qpush_pop
, output wire logic                   o_qpop_pop
, output wire logic                   o_lk_vld_w
, output wire logic [ENGID_W - 1:0]   o_lk_engid_w
, output wire stk_pkg::opcode_t       o_lk_opcode_w
, output wire logic                   o_lk_isfull_w
, output wire logic                   o_lk_dat_vld_w
, output wire stk_pkg::dat_t          o_lk_dat_w
, output wire logic                   o_al_alloc
, input wire logic                    clk
, input wire logic                    i_arst_n
);

  import stk_pkg::*;

  // Requester slots on the issue arbiter
  localparam int IDX_PUSH = 0;
  localparam int IDX_POP = 1;

  logic [1:0]                         deq_req;
  logic [1:0]                         deq_gnt;
  logic                               deq_ack;
  logic                               iss_push;
  logic                               iss_pop;

  // A head may go once its engine is idle
  assign deq_req[IDX_PUSH] = ~i_qpush_empty & ~i_qpush_blocked;
  assign deq_req[IDX_POP]  = ~i_qpop_empty & ~i_qpop_blocked;

  // Allocator busy stalls both queues
  assign deq_ack = ~i_al_busy_r & (deq_req != '0);

  stk_rr_arb #(.W(2)) u_deq_arb (
    .i_req                    (deq_req)
  , .i_ack                    (deq_ack)
  , .o_gnt                    (deq_gnt)
  , .clk                      (clk)
  , .i_arst_n                 (i_arst_n)
  );

  assign iss_push = deq_ack & deq_gnt[IDX_PUSH];
  assign iss_pop  = deq_ack & deq_gnt[IDX_POP];

  // Retire the issued head
  assign o_qpush_pop = iss_push;
  assign o_qpop_pop  = iss_pop;

  assign o_lk_vld_w = deq_ack;

  // AND-OR select of the winning head
  assign o_lk_engid_w = ({ENGID_W{iss_push}} & i_qpush_head_engid)
                      | ({ENGID_W{iss_pop}} & i_qpop_head_engid);

  // Opcode follows from which queue won
  assign o_lk_opcode_w = ({OPCODE_W{iss_push}} & OPCODE_PUSH)
                       | ({OPCODE_W{iss_pop}} & OPCODE_POP);

  // Full status only matters to a push
  assign o_lk_isfull_w = iss_push & i_al_full_r;

  // Payload qualified by data valid
  assign o_lk_dat_vld_w = iss_push;
  assign o_lk_dat_w     = i_qpush_head_dat;

  // Every push claims a new line
  assign o_al_alloc = iss_push;

endmodule : stk_issue

`default_nettype wire

// File: hw/stk_pipe_ad.sv
`timescale 1ns/1ps
`default_nettype none

module stk_pipe_ad #(
  parameter int ENGS_N = stk_pkg::ENGS_N_DEFAULT
, parameter int QUEUE_DEPTH = stk_pkg::QUEUE_DEPTH_DEFAULT
, localparam int ENGID_W = $clog2(ENGS_N)
) (
  // Engine commands
  input wire logic [ENGS_N - 1:0]                 i_cmd_vld
, input wire stk_pkg::opcode_t [ENGS_N - 1:0]     i_cmd_opcode
, input wire stk_pkg::dat_t [ENGS_N - 1:0]        i_cmd_dat
, output wire logic [ENGS_N - 1:0]                o_cmd_ack
  // Look-up stage
, output wire logic                               o_lk_vld_w
, output wire logic [ENGID_W - 1:0]               o_lk_engid_w
, output wire stk_pkg::opcode_t                   o_lk_opcode_w
, output wire logic                               o_lk_isfull_w
, output wire logic                               o_lk_dat_vld_w
, output wire stk_pkg::dat_t                      o_lk_dat_w
  // Allocator
, input wire logic                                i_al_full_r
, input wire logic                                i_al_busy_r
, output wire logic                               o_al_alloc
  // Writeback
, input wire logic                                i_wrbk_uc_vld_r
, input wire logic [ENGID_W - 1:0]                i_wrbk_uc_engid_r
, input wire logic                                clk
, input wire logic                                i_arst_n
);

  import stk_pkg::*;

  // Push queue entry is engine ID plus payload
  localparam int QPUSH_W = ENGID_W + DAT_W;

  logic                               qpush_push;
  logic [QPUSH_W - 1:0]               qpush_push_dat;
  logic                               qpush_pop;
  logic [QPUSH_W - 1:0]               qpush_pop_dat;
  logic                               qpush_full;
  logic                               qpush_empty;
  logic                               qpush_blocked;

  logic                               qpop_push;
  logic [ENGID_W - 1:0]               qpop_push_dat;
  logic                               qpop_pop;
  logic [ENGID_W - 1:0]               qpop_pop_dat;
  logic                               qpop_full;
  logic                               qpop_empty;
  logic                               qpop_blocked;

  // Split the push head back into its fields
  logic [ENGID_W - 1:0]               qpush_head_engid;
  dat_t                               qpush_head_dat;

  assign qpush_head_engid = qpush_pop_dat[DAT_W +: ENGID_W];
  assign qpush_head_dat   = qpush_pop_dat[DAT_W - 1:0];

  // Decode, arbitrate and enqueue
  stk_cmd_enq #(.ENGS_N(ENGS_N)) u_enq (
    .i_cmd_vld                (i_cmd_vld)
  , .i_cmd_opcode             (i_cmd_opcode)
  , .i_cmd_dat                (i_cmd_dat)
  , .i_qpush_full             (qpush_full)
  , .i_qpop_full              (qpop_full)
  , .o_cmd_ack                (o_cmd_ack)
  , .o_qpush_push             (qpush_push)
  , .o_qpush_dat              (qpush_push_dat)
  , .o_qpop_push              (qpop_push)
  , .o_qpop_dat               (qpop_push_dat)
  , .clk                      (clk)
  , .i_arst_n                 (i_arst_n)
  );

  stk_cmd_queue #(.DEPTH(QUEUE_DEPTH), .W(QPUSH_W)) u_qpush (
    .i_push                   (qpush_push)
  , .i_push_dat               (qpush_push_dat)
  , .i_pop                    (qpush_pop)
  , .o_pop_dat                (qpush_pop_dat)
  , .o_full                   (qpush_full)
  , .o_empty                  (qpush_empty)
  , .clk                      (clk)
  , .i_arst_n                 (i_arst_n)
  );

  stk_cmd_queue #(.DEPTH(QUEUE_DEPTH), .W(ENGID_W)) u_qpop (
    .i_push                   (qpop_push)
  , .i_push_dat               (qpop_push_dat)
  , .i_pop                    (qpop_pop)
  , .o_pop_dat                (qpop_pop_dat)
  , .o_full                   (qpop_full)
  , .o_empty                  (qpop_empty)
  , .clk                      (clk)
  , .i_arst_n                 (i_arst_n)
  );

  // Issued engine is marked busy until its writeback returns
  stk_active_set #(.ENGS_N(ENGS_N)) u_active (
    .i_issue                  (o_lk_vld_w)
  , .i_issue_engid            (o_lk_engid_w)
  , .i_wrbk_vld               (i_wrbk_uc_vld_r)
  , .i_wrbk_engid             (i_wrbk_uc_engid_r)
  , .i_qpush_head_engid       (qpush_head_engid)
  , .i_qpop_head_engid        (qpop_pop_dat)
  , .o_qpush_blocked          (qpush_blocked)
  , .o_qpop_blocked           (qpop_blocked)
  , .clk                      (clk)
  , .i_arst_n                 (i_arst_n)
  );

  stk_issue #(.ENGS_N(ENGS_N)) u_issue (
    .i_qpush_empty            (qpush_empty)
  , .i_qpush_head_engid       (qpush_head_engid)
  , .i_qpush_head_dat         (qpush_head_dat)
  , .i_qpush_blocked          (qpush_blocked)
  , .i_qpop_empty             (qpop_empty)
  , .i_qpop_head_engid        (qpop_pop_dat)
  , .i_qpop_blocked           (qpop_blocked)
  , .i_al_busy_r              (i_al_busy_r)
  , .i_al_full_r              (i_al_full_r)
  , .o_qpush_pop              (qpush_pop)
  , .o_qpop_pop               (qpop_pop)
  , .o_lk_vld_w               (o_lk_vld_w)
  , .o_lk_engid_w             (o_lk_engid_w)
  , .o_lk_opcode_w            (o_lk_opcode_w)
  , .o_lk_isfull_w            (o_lk_isfull_w)
  , .o_lk_dat_vld_w           (o_lk_dat_vld_w)
  , .o_lk_dat_w               (o_lk_dat_w)
  , .o_al_alloc               (o_al_alloc)
  , .clk                      (clk)
  , .i_arst_n                 (i_arst_n)
  );

endmodule : stk_pipe_ad

`default_nettype wire

// File: testbench/tb_stk_pipe_ad.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stk_pipe_ad;

  import stk_pkg::*;

  localparam int ENGS_N = ENGS_N_DEFAULT;
  localparam int QUEUE_DEPTH = QUEUE_DEPTH_DEFAULT;
  localparam int ENGID_W = $clog2(ENGS_N);

  // Phase lengths in cycles
  localparam int RST_CYCLES = 16;
  localparam int RAND_CYCLES = 2000;
  localparam int HOLD_CYCLES = 24;
  localparam int FAIR_CYCLES = 200;
  localparam int DRAIN_CYCLES = 300;
  localparam int STIM_CYCLES = RST_CYCLES + 2 + RAND_CYCLES + HOLD_CYCLES
                             + FAIR_CYCLES + DRAIN_CYCLES;
  localparam int LIMIT_CYCLES = 4 * STIM_CYCLES;

  // Engine behavior per phase
  localparam int PH_RAND = 0;
  localparam int PH_HOLD = 1;
  localparam int PH_FAIR = 2;
  localparam int PH_DRAIN = 3;

  logic                               clk;
  logic                               i_arst_n;
  logic [ENGS_N - 1:0]                i_cmd_vld;
  opcode_t [ENGS_N - 1:0]             i_cmd_opcode;
  dat_t [ENGS_N - 1:0]                i_cmd_dat;
  logic [ENGS_N - 1:0]                o_cmd_ack;
  logic                               o_lk_vld_w;
  logic [ENGID_W - 1:0]               o_lk_engid_w;
  opcode_t                            o_lk_opcode_w;
  logic                               o_lk_isfull_w;
  logic                               o_lk_dat_vld_w;
  dat_t                               o_lk_dat_w;
  logic                               i_al_full_r;
  logic                               i_al_busy_r;
  logic                               o_al_alloc;
  logic                               i_wrbk_uc_vld_r;
  logic [ENGID_W - 1:0]               i_wrbk_uc_engid_r;

  int                                 seed;
  int                                 err_cnt;
  int                                 ack_cnt;
  int                                 iss_cnt;
  int                                 wrbk_cnt;
  int                                 cycle_cnt = 0;
  int                                 post_rst;
  int                                 fair_run;
  // Acks seen at the last falling edge
  logic [ENGS_N - 1:0]                ack_seen;
  // Engines issued and waiting for writeback
  logic [ENGS_N - 1:0]                inflight;
  // Reference queues of acked commands
  logic [ENGID_W - 1:0]               mq_push_eng[$];
  dat_t                               mq_push_dat[$];
  logic [ENGID_W - 1:0]               mq_pop_eng[$];
  // Circular history of the last ENGS_N acked engines
  logic [ENGID_W - 1:0]               fair_hist[ENGS_N];

  stk_pipe_ad #(.ENGS_N(ENGS_N), .QUEUE_DEPTH(QUEUE_DEPTH)) dut_i (
    .i_cmd_vld                (i_cmd_vld)
  , .i_cmd_opcode             (i_cmd_opcode)
  , .i_cmd_dat                (i_cmd_dat)
  , .o_cmd_ack                (o_cmd_ack)
  , .o_lk_vld_w               (o_lk_vld_w)
  , .o_lk_engid_w             (o_lk_engid_w)
  , .o_lk_opcode_w            (o_lk_opcode_w)
  , .o_lk_isfull_w            (o_lk_isfull_w)
  , .o_lk_dat_vld_w           (o_lk_dat_vld_w)
  , .o_lk_dat_w               (o_lk_dat_w)
  , .i_al_full_r              (i_al_full_r)
  , .i_al_busy_r              (i_al_busy_r)
  , .o_al_alloc               (o_al_alloc)
  , .i_wrbk_uc_vld_r          (i_wrbk_uc_vld_r)
  , .i_wrbk_uc_engid_r        (i_wrbk_uc_engid_r)
  , .clk                      (clk)
  , .i_arst_n                 (i_arst_n)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Backstop against a stuck run
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  task report_mismatch(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  // Next engine, allocator and writeback inputs for one cycle
  task drive_cycle(input int phase);
    logic [ENGS_N - 1:0]              vld_n;
    opcode_t [ENGS_N - 1:0]           op_n;
    dat_t [ENGS_N - 1:0]              dat_n;
    int                               wb_eng;
    int                               wb_roll;
    vld_n = i_cmd_vld;
    op_n  = i_cmd_opcode;
    dat_n = i_cmd_dat;
    for (int e = 0; e < ENGS_N; e++) begin
      // A command stays until its ack and an undefined opcode lasts one cycle
      if (ack_seen[e] || !vld_n[e]
          || (op_n[e] != OPCODE_PUSH && op_n[e] != OPCODE_POP)) begin
        if (phase == PH_DRAIN) begin
          vld_n[e] = 1'b0;
        end else if (phase == PH_RAND && (($random(seed) & 3) == 0)) begin
          // Idle engine with a junk opcode
          vld_n[e] = 1'b0;
          op_n[e]  = opcode_t'($random(seed));
        end else if (phase == PH_RAND && (($random(seed) & 7) == 0)) begin
          // Valid request with an undefined opcode that must never be acked
          vld_n[e] = 1'b1;
          op_n[e]  = (($random(seed) & 1) != 0) ? opcode_t'(3) : opcode_t'(0);
        end else begin
          vld_n[e] = 1'b1;
          if (phase == PH_RAND && (($random(seed) & 1) != 0)) begin
            op_n[e] = OPCODE_POP;
          end else begin
            op_n[e] = OPCODE_PUSH;
          end
          dat_n[e] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
      end
    end
    i_cmd_vld    <= vld_n;
    i_cmd_opcode <= op_n;
    i_cmd_dat    <= dat_n;
    case (phase)
      PH_HOLD:  i_al_busy_r <= 1'b1;
      PH_DRAIN: i_al_busy_r <= 1'b0;
      default:  i_al_busy_r <= (($random(seed) & 3) == 0);
    endcase
    i_al_full_r <= (($random(seed) & 3) == 0);
    // Writeback after a random delay, only for an engine in flight
    wb_eng  = ($random(seed) & 32'h7fffffff) % ENGS_N;
    wb_roll = $random(seed) & 1;
    if (inflight[wb_eng] && wb_roll == 0) begin
      i_wrbk_uc_vld_r   <= 1'b1;
      i_wrbk_uc_engid_r <= ENGID_W'(wb_eng);
    end else begin
      i_wrbk_uc_vld_r <= 1'b0;
    end
  endtask

  // Reference model and checks for one settled cycle
  task check_cycle();
    logic                             fair_ok;
    logic [ENGS_N - 1:0]              cov_mask;
    // Fairness holds only when every engine can compete
    fair_ok = &i_cmd_vld;
    for (int e = 0; e < ENGS_N; e++) begin
      if (i_cmd_opcode[e] != OPCODE_PUSH && i_cmd_opcode[e] != OPCODE_POP) begin
        fair_ok = 1'b0;
      end
      if (i_cmd_opcode[e] == OPCODE_PUSH && mq_push_eng.size() >= QUEUE_DEPTH) begin
        fair_ok = 1'b0;
      end
      if (i_cmd_opcode[e] == OPCODE_POP && mq_pop_eng.size() >= QUEUE_DEPTH) begin
        fair_ok = 1'b0;
      end
    end
    assert ($onehot0(o_cmd_ack))
      else report_mismatch($sformatf("ack %b has more than one bit set", o_cmd_ack));
    // Issue is handled before acks since an entry acked now is not yet at a head
    if (o_lk_vld_w) begin
      iss_cnt++;
      assert (!i_al_busy_r) else report_mismatch("issue while allocator busy");
      assert (!inflight[o_lk_engid_w])
        else report_mismatch($sformatf("engine %0d issued twice", o_lk_engid_w));
      inflight[o_lk_engid_w] = 1'b1;
      if (o_lk_opcode_w == OPCODE_PUSH) begin
        assert (mq_push_eng.size() > 0) else report_mismatch("push issue with none queued");
        if (mq_push_eng.size() > 0) begin
          assert (o_lk_engid_w == mq_push_eng[0] && o_lk_dat_w == mq_push_dat[0])
            else report_mismatch($sformatf("push issue engine %0d, expected %0d",
                                           o_lk_engid_w, mq_push_eng[0]));
          void'(mq_push_eng.pop_front());
          void'(mq_push_dat.pop_front());
        end
        assert (o_lk_dat_vld_w && o_al_alloc && o_lk_isfull_w == i_al_full_r)
          else report_mismatch("push issue side outputs wrong");
      end else if (o_lk_opcode_w == OPCODE_POP) begin
        assert (mq_pop_eng.size() > 0) else report_mismatch("pop issue with none queued");
        if (mq_pop_eng.size() > 0) begin
          assert (o_lk_engid_w == mq_pop_eng[0])
            else report_mismatch($sformatf("pop issue engine %0d, expected %0d",
                                           o_lk_engid_w, mq_pop_eng[0]));
          void'(mq_pop_eng.pop_front());
        end
        assert (!o_lk_dat_vld_w && !o_al_alloc && !o_lk_isfull_w)
          else report_mismatch("pop issue raised push side outputs");
      end else begin
        report_mismatch($sformatf("issue with opcode %0d", o_lk_opcode_w));
      end
    end else begin
      assert (!o_lk_dat_vld_w && !o_al_alloc) else report_mismatch("push outputs without issue");
    end
    if (i_wrbk_uc_vld_r) begin
      wrbk_cnt++;
      inflight[i_wrbk_uc_engid_r] = 1'b0;
    end
    for (int e = 0; e < ENGS_N; e++) begin
      if (o_cmd_ack[e]) begin
        ack_cnt++;
        assert (i_cmd_vld[e] && (i_cmd_opcode[e] == OPCODE_PUSH
                                 || i_cmd_opcode[e] == OPCODE_POP))
          else report_mismatch($sformatf("ack for engine %0d without legal command", e));
        if (i_cmd_opcode[e] == OPCODE_PUSH) begin
          mq_push_eng.push_back(ENGID_W'(e));
          mq_push_dat.push_back(i_cmd_dat[e]);
        end else if (i_cmd_opcode[e] == OPCODE_POP) begin
          mq_pop_eng.push_back(ENGID_W'(e));
        end
        if (fair_ok) begin
          fair_hist[fair_run % ENGS_N] = ENGID_W'(e);
          fair_run++;
        end
      end
    end
    if (!fair_ok) begin
      fair_run = 0;
    end else if (o_cmd_ack != '0 && fair_run >= ENGS_N) begin
      cov_mask = '0;
      for (int k = 0; k < ENGS_N; k++) begin
        cov_mask[fair_hist[k]] = 1'b1;
      end
      assert (&cov_mask)
        else report_mismatch($sformatf("last %0d acks cover only %b", ENGS_N, cov_mask));
    end
    assert (mq_push_eng.size() <= QUEUE_DEPTH && mq_pop_eng.size() <= QUEUE_DEPTH)
      else report_mismatch("acks outran queue depth");
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clk) begin
    if (!i_arst_n || post_rst < 2) begin
      assert (o_cmd_ack == '0 && !o_lk_vld_w && !o_lk_dat_vld_w && !o_al_alloc)
        else report_mismatch("outputs active during or right after reset");
    end
    if (i_arst_n) begin
      post_rst++;
      check_cycle();
    end
    ack_seen = o_cmd_ack;
  end

  initial begin
    seed              = 32'h8f59b4cc;
    err_cnt           = 0;
    ack_cnt           = 0;
    iss_cnt           = 0;
    wrbk_cnt          = 0;
    post_rst          = 0;
    fair_run          = 0;
    ack_seen          = '0;
    inflight          = '0;
    i_arst_n          = 1'b0;
    i_cmd_vld         = '0;
    i_cmd_opcode      = '0;
    i_cmd_dat         = '0;
    i_al_full_r       = 1'b0;
    i_al_busy_r       = 1'b0;
    i_wrbk_uc_vld_r   = 1'b0;
    i_wrbk_uc_engid_r = '0;
    repeat (RST_CYCLES) @(posedge clk);
    i_arst_n <= 1'b1;
    repeat (2) @(posedge clk);
    repeat (RAND_CYCLES) begin
      drive_cycle(PH_RAND);
      @(posedge clk);
    end
    // Every engine valid while issue is held off until the queues fill
    repeat (HOLD_CYCLES) begin
      drive_cycle(PH_HOLD);
      @(posedge clk);
    end
    // All pushes so the enqueue round robin is fully loaded
    repeat (FAIR_CYCLES) begin
      drive_cycle(PH_FAIR);
      @(posedge clk);
    end
    for (int n = 0; n < DRAIN_CYCLES; n++) begin
      if (i_cmd_vld == '0 && mq_push_eng.size() == 0 && mq_pop_eng.size() == 0) begin
        break;
      end
      drive_cycle(PH_DRAIN);
      @(posedge clk);
    end
    if (i_cmd_vld != '0 || mq_push_eng.size() != 0 || mq_pop_eng.size() != 0) begin
      $display("Drain incomplete: %0d push and %0d pop commands never issued",
               mq_push_eng.size(), mq_pop_eng.size());
      err_cnt++;
    end
    $display("Summary: acks=%0d issues=%0d writebacks=%0d errors=%0d",
             ack_cnt, iss_cnt, wrbk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : tb_stk_pipe_ad

`default_nettype wire

// File: stk_pipe_ad.f
hw/stk_pkg.sv
hw/stk_rr_arb.sv
hw/stk_cmd_queue.sv
hw/stk_cmd_enq.sv
hw/stk_active_set.sv
hw/stk_issue.sv
hw/stk_pipe_ad.sv
testbench/tb_stk_pipe_ad.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_stk_pipe_ad \
		-f stk_pipe_ad.f --Mdir obj_dir -o tb_stk_pipe_ad
	./obj_dir/tb_stk_pipe_ad | tee sim.log
	grep -qx "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
